//--- rtl/ycr_mem_pkg.sv
package ycr_mem_pkg;

// ----------------------------------------------------------
// Core data-memory port widths
// ----------------------------------------------------------
localparam int unsigned YCR_DMEM_AWIDTH = 32;   // Address width
localparam int unsigned YCR_DMEM_DWIDTH = 32;   // Data width

typedef logic [YCR_DMEM_AWIDTH-1:0] dmem_addr_t;   // Core address word
typedef logic [YCR_DMEM_DWIDTH-1:0] dmem_data_t;   // Core data word

// ----------------------------------------------------------
// Request and response encodings
// ----------------------------------------------------------
typedef enum logic {
   READ  = 1'b0,                                // Load
   WRITE = 1'b1                                 // Store
} dmem_cmd_e;

typedef enum logic [1:0] {
   BYTE  = 2'b00,                               // 8-bit access
   HWORD = 2'b01,                               // 16-bit access
   WORD  = 2'b10                                // 32-bit access
} dmem_width_e;

// Response is a one-cycle pulse
typedef enum logic [1:0] {
   IDLE = 2'b00,                                // No response this cycle
   RDY  = 2'b01,                                // Completed ok
   ER   = 2'b10                                 // Bus error
} dmem_resp_e;

endpackage : ycr_mem_pkg

//--- rtl/ycr_wb_pkg.sv
package ycr_wb_pkg;

// ----------------------------------------------------------
// Wishbone data bus geometry
// ----------------------------------------------------------
localparam int unsigned YCR_WB_WIDTH  = 32;                 // Bus width
localparam int unsigned YCR_WB_SEL_W  = YCR_WB_WIDTH / 8;   // Byte enables
localparam int unsigned YCR_WB_BYTE_W = 8;                  // Bits per lane

typedef logic [YCR_WB_SEL_W-1:0] wb_sel_t;   // Byte-enable vector
typedef logic [YCR_WB_WIDTH-1:0] wb_data_t;  // Bus data word

// Base lane masks, shifted up by the byte offset
localparam wb_sel_t YCR_WB_SEL_BYTE  = 4'b0001;   // Single lane
localparam wb_sel_t YCR_WB_SEL_HWORD = 4'b0011;   // Two lanes
localparam wb_sel_t YCR_WB_SEL_WORD  = 4'b1111;   // All lanes

endpackage : ycr_wb_pkg

//--- rtl/ycr_reset_sync.sv
`timescale 1ns/10ps

module ycr_reset_sync #(
   parameter int unsigned RST_SYNC_STAGES = 2         // Flops in the chain
) (
   input  logic core_clk_i,                           // Core clock
   input  logic rst_n_i,                              // Power-up reset
   input  logic cpu_intf_rst_n_i,                     // CPU interface reset
   output logic rst_n_sync_o                          // Clock-aligned reset
);

logic                       rst_n_comb;               // Either source asserts
logic [RST_SYNC_STAGES-1:0] sync_ff;                  // Synchronizer chain

assign rst_n_comb = rst_n_i & cpu_intf_rst_n_i;       // Async assert path

// Assert at once, release after RST_SYNC_STAGES edges
always_ff @(posedge core_clk_i or negedge rst_n_comb) begin
   if (!rst_n_comb) begin
      sync_ff <= '0;
   end else begin
      sync_ff <= {sync_ff[RST_SYNC_STAGES-2:0], cpu_intf_rst_n_i};
   end
end

assign rst_n_sync_o = sync_ff[RST_SYNC_STAGES-1];     // Last stage

endmodule : ycr_reset_sync

//--- rtl/ycr_dmem_req_capture.sv
`timescale 1ns/10ps

module ycr_dmem_req_capture (
   input  logic                     core_clk_i,          // Core clock
   input  logic                     rst_n_i,             // Synchronized reset
   // Core request port
   input  logic                     core_dmem_req_i,     // Request
   input  ycr_mem_pkg::dmem_cmd_e   core_dmem_cmd_i,     // Read or write
   input  ycr_mem_pkg::dmem_width_e core_dmem_width_i,   // Access width
   input  ycr_mem_pkg::dmem_addr_t  core_dmem_addr_i,    // Address
   input  ycr_mem_pkg::dmem_data_t  core_dmem_wdata_i,   // Write data
   output logic                     core_dmem_req_ack_o, // Request taken
   // Toward the bus master
   input  logic                     pend_take_i,         // Master launches entry
   output logic                     pend_valid_o,        // Entry held
   output ycr_mem_pkg::dmem_cmd_e   pend_cmd_o,          // Held command
   output ycr_mem_pkg::dmem_width_e pend_width_o,        // Held width
   output ycr_mem_pkg::dmem_addr_t  pend_addr_o,         // Held address
   output ycr_mem_pkg::dmem_data_t  pend_wdata_o         // Held write data
);

// ----------------------------------------------------------
// Acceptance
// ----------------------------------------------------------
// One-entry buffer; a second request may land here while
// the first one is still out on Wishbone
assign core_dmem_req_ack_o = core_dmem_req_i & ~pend_valid_o;   // Only when empty

// ----------------------------------------------------------
// Valid flag
// ----------------------------------------------------------
always_ff @(posedge core_clk_i or negedge rst_n_i) begin
   if (!rst_n_i) begin
      pend_valid_o <= 1'b0;
   end else if (core_dmem_req_ack_o) begin
      pend_valid_o <= 1'b1;                       // Filled on accept
   end else if (pend_take_i) begin
      pend_valid_o <= 1'b0;                       // Freed at launch
   end
end

// ----------------------------------------------------------
// Request fields
// ----------------------------------------------------------
always_ff @(posedge core_clk_i) begin
   if (core_dmem_req_ack_o) begin
      pend_cmd_o   <= core_dmem_cmd_i;            // Load or store
      pend_width_o <= core_dmem_width_i;          // Byte/half/word
      pend_addr_o  <= core_dmem_addr_i;           // Full address kept
      pend_wdata_o <= core_dmem_wdata_i;          // Unshifted store data
   end
end

endmodule : ycr_dmem_req_capture

//--- rtl/ycr_dmem_lane_align.sv
`timescale 1ns/10ps

module ycr_dmem_lane_align (
   // Request path
   input  ycr_mem_pkg::dmem_width_e pend_width_i,   // Pending access width
   input  ycr_mem_pkg::dmem_addr_t  pend_addr_i,    // Pending address
   input  ycr_mem_pkg::dmem_data_t  pend_wdata_i,   // Pending store data
   output ycr_wb_pkg::wb_sel_t      wb_sel_o,       // Byte enables
   output ycr_wb_pkg::wb_data_t     wb_wdata_o,     // Lane-shifted store data
   // Return path
   input  ycr_mem_pkg::dmem_width_e rd_width_i,     // Width of access on bus
   input  logic [1:0]               rd_offset_i,    // Byte offset of that access
   input  ycr_wb_pkg::wb_data_t     wb_rdata_i,     // Registered bus read data
   output ycr_mem_pkg::dmem_data_t  core_rdata_o    // Aligned load data
);

import ycr_mem_pkg::*;
import ycr_wb_pkg::*;

logic [1:0] wr_offset;                            // Store byte offset
logic [4:0] wr_shift;                             // Store shift in bits
logic [4:0] rd_shift;                             // Load shift in bits
wb_data_t   rd_shifted;                           // Load data at lane 0

// ----------------------------------------------------------
// Request path
// ----------------------------------------------------------
assign wr_offset = pend_addr_i[1:0];
assign wr_shift  = {wr_offset, 3'b000};           // 8 x offset

assign wb_wdata_o = pend_wdata_i << wr_shift;     // Move data onto its lanes

always_comb begin
   case (pend_width_i)
      BYTE:    wb_sel_o = YCR_WB_SEL_BYTE << wr_offset;             // One lane
      HWORD:   wb_sel_o = YCR_WB_SEL_HWORD << {wr_offset[1], 1'b0}; // Lane 0 or 2
      default: wb_sel_o = YCR_WB_SEL_WORD;                          // Full word
   endcase
end

// ----------------------------------------------------------
// Return path
// ----------------------------------------------------------
assign rd_shift   = {rd_offset_i, 3'b000};
assign rd_shifted = wb_rdata_i >> rd_shift;       // Bring lane down to bit 0

// Zero-extend to the access width
always_comb begin
   case (rd_width_i)
      BYTE:    core_rdata_o = dmem_data_t'(rd_shifted[YCR_WB_BYTE_W-1:0]);
      HWORD:   core_rdata_o = dmem_data_t'(rd_shifted[2*YCR_WB_BYTE_W-1:0]);
      default: core_rdata_o = rd_shifted;         // Word passes as is
   endcase
end

endmodule : ycr_dmem_lane_align

//--- rtl/ycr_dmem_wb_master.sv
`timescale 1ns/10ps

module ycr_dmem_wb_master (
   input  logic                     core_clk_i,         // Core clock
   input  logic                     rst_n_i,            // Synchronized reset
   // From capture stage and lane aligner
   input  logic                     pend_valid_i,       // Request waiting
   input  ycr_mem_pkg::dmem_cmd_e   pend_cmd_i,         // Read or write
   input  ycr_mem_pkg::dmem_width_e pend_width_i,       // Access width
   input  ycr_mem_pkg::dmem_addr_t  pend_addr_i,        // Address
   input  ycr_wb_pkg::wb_sel_t      sel_i,              // Byte enables
   input  ycr_wb_pkg::wb_data_t     wdata_i,            // Shifted store data
   output logic                     pend_take_o,        // Launch strobe
   // Wishbone master
   output logic                     wbd_dmem_stb_o,     // Strobe/request
   output ycr_wb_pkg::wb_data_t     wbd_dmem_adr_o,     // Address
   output logic                     wbd_dmem_we_o,      // Write
   output ycr_wb_pkg::wb_data_t     wbd_dmem_dat_o,     // Data out
   output ycr_wb_pkg::wb_sel_t      wbd_dmem_sel_o,     // Byte enable
   input  ycr_wb_pkg::wb_data_t     wbd_dmem_dat_i,     // Data in
   input  logic                     wbd_dmem_ack_i,     // Acknowledge
   input  logic                     wbd_dmem_err_i,     // Error
   // Return toward the core
   output ycr_mem_pkg::dmem_width_e rd_width_o,         // Width of access
   output logic [1:0]               rd_offset_o,        // Byte offset of access
   output ycr_wb_pkg::wb_data_t     rd_data_o,          // Captured bus data
   output ycr_mem_pkg::dmem_resp_e  core_dmem_resp_o    // Response pulse
);

import ycr_mem_pkg::*;

typedef enum logic [1:0] {
   ST_IDLE = 2'b00,                               // Waiting for a request
   ST_BUS  = 2'b01,                               // Cycle on Wishbone
   ST_RESP = 2'b10                                // Response pulse
} state_e;

state_e state;                                    // FSM state
logic   bus_done;                                 // Slave ended the cycle

assign pend_take_o = (state == ST_IDLE) & pend_valid_i;   // Launch from idle only
assign bus_done    = (state == ST_BUS) & (wbd_dmem_ack_i | wbd_dmem_err_i);

// ----------------------------------------------------------
// Control FSM
// ----------------------------------------------------------
always_ff @(posedge core_clk_i or negedge rst_n_i) begin
   if (!rst_n_i) begin
      state            <= ST_IDLE;
      wbd_dmem_stb_o   <= 1'b0;
      wbd_dmem_we_o    <= 1'b0;
      core_dmem_resp_o <= IDLE;
   end else begin
      case (state)
         ST_IDLE: begin
            if (pend_take_o) begin
               wbd_dmem_stb_o <= 1'b1;            // Raise stb
               wbd_dmem_we_o  <= (pend_cmd_i == WRITE);
               state          <= ST_BUS;
            end
         end
         ST_BUS: begin
            if (bus_done) begin
               wbd_dmem_stb_o   <= 1'b0;          // Drop stb for one cycle min
               wbd_dmem_we_o    <= 1'b0;
               core_dmem_resp_o <= wbd_dmem_err_i ? ER : RDY;   // Err wins
               state            <= ST_RESP;
            end
         end
         ST_RESP: begin
            core_dmem_resp_o <= IDLE;             // End of pulse
            state            <= ST_IDLE;
         end
         default: state <= ST_IDLE;
      endcase
   end
end

// ----------------------------------------------------------
// Bus fields and return data
// ----------------------------------------------------------
always_ff @(posedge core_clk_i) begin
   if (pend_take_o) begin
      wbd_dmem_adr_o <= pend_addr_i;              // Address unchanged
      wbd_dmem_dat_o <= wdata_i;
      wbd_dmem_sel_o <= sel_i;
      rd_width_o     <= pend_width_i;             // Kept for load extract
      rd_offset_o    <= pend_addr_i[1:0];
   end
   if (bus_done) begin
      // Stores and errors hand back zero
      rd_data_o <= (wbd_dmem_we_o | wbd_dmem_err_i) ? '0 : wbd_dmem_dat_i;
   end
end

endmodule : ycr_dmem_wb_master

//--- rtl/ycr_intf.sv
`timescale 1ns/10ps

module ycr_intf #(
   parameter int unsigned RST_SYNC_STAGES = 2               // Reset sync depth
) (
   input  logic                     core_clk_i,             // Core clock
   input  logic                     rst_n_i,                // Power-up reset
   input  logic                     cpu_intf_rst_n_i,       // CPU interface reset
   // Core data memory port
   input  logic                     core_dmem_req_i,        // Request
   input  ycr_mem_pkg::dmem_cmd_e   core_dmem_cmd_i,        // Command
   input  ycr_mem_pkg::dmem_width_e core_dmem_width_i,      // Width
   input  ycr_mem_pkg::dmem_addr_t  core_dmem_addr_i,       // Address
   input  ycr_mem_pkg::dmem_data_t  core_dmem_wdata_i,      // Write data
   output logic                     core_dmem_req_ack_o,    // Request taken
   output ycr_mem_pkg::dmem_data_t  core_dmem_rdata_o,      // Read data
   output ycr_mem_pkg::dmem_resp_e  core_dmem_resp_o,       // Response
   // Wishbone data master
   output logic                     wbd_dmem_stb_o,         // Strobe/request
   output ycr_wb_pkg::wb_data_t     wbd_dmem_adr_o,         // Address
   output logic                     wbd_dmem_we_o,          // Write
   output ycr_wb_pkg::wb_data_t     wbd_dmem_dat_o,         // Data out
   output ycr_wb_pkg::wb_sel_t      wbd_dmem_sel_o,         // Byte enable
   input  ycr_wb_pkg::wb_data_t     wbd_dmem_dat_i,         // Data in
   input  logic                     wbd_dmem_ack_i,         // Acknowledge
   input  logic                     wbd_dmem_err_i          // Error
);

import ycr_mem_pkg::*;
import ycr_wb_pkg::*;

logic        rst_n_sync;                          // Bridge reset
logic        pend_valid;                          // Capture register full
logic        pend_take;                           // Master launches entry
dmem_cmd_e   pend_cmd;
dmem_width_e pend_width;
dmem_addr_t  pend_addr;
dmem_data_t  pend_wdata;
wb_sel_t     wb_sel;                              // Aligned byte enables
wb_data_t    wb_wdata;                            // Aligned store data
dmem_width_e rd_width;                            // Width of access on bus
logic [1:0]  rd_offset;                           // Offset of access on bus
wb_data_t    rd_data;                             // Captured bus data

// ----------------------------------------------------------
// Reset synchronizer
// ----------------------------------------------------------
ycr_reset_sync #(
   .RST_SYNC_STAGES (RST_SYNC_STAGES)
) i_reset_sync (
   .core_clk_i       (core_clk_i      ),
   .rst_n_i          (rst_n_i         ),
   .cpu_intf_rst_n_i (cpu_intf_rst_n_i),
   .rst_n_sync_o     (rst_n_sync      )
);

// ----------------------------------------------------------
// Bridge stages
// ----------------------------------------------------------
ycr_dmem_req_capture i_req_capture (
   .core_clk_i          (core_clk_i         ),
   .rst_n_i             (rst_n_sync         ),
   .core_dmem_req_i     (core_dmem_req_i    ),
   .core_dmem_cmd_i     (core_dmem_cmd_i    ),
   .core_dmem_width_i   (core_dmem_width_i  ),
   .core_dmem_addr_i    (core_dmem_addr_i   ),
   .core_dmem_wdata_i   (core_dmem_wdata_i  ),
   .core_dmem_req_ack_o (core_dmem_req_ack_o),
   .pend_take_i         (pend_take          ),
   .pend_valid_o        (pend_valid         ),
   .pend_cmd_o          (pend_cmd           ),
   .pend_width_o        (pend_width         ),
   .pend_addr_o         (pend_addr          ),
   .pend_wdata_o        (pend_wdata         )
);

ycr_dmem_lane_align i_lane_align (
   .pend_width_i (pend_width       ),
   .pend_addr_i  (pend_addr        ),
   .pend_wdata_i (pend_wdata       ),
   .wb_sel_o     (wb_sel           ),
   .wb_wdata_o   (wb_wdata         ),
   .rd_width_i   (rd_width         ),
   .rd_offset_i  (rd_offset        ),
   .wb_rdata_i   (rd_data          ),
   .core_rdata_o (core_dmem_rdata_o)
);

ycr_dmem_wb_master i_wb_master (
   .core_clk_i       (core_clk_i      ),
   .rst_n_i          (rst_n_sync      ),
   .pend_valid_i     (pend_valid      ),
   .pend_cmd_i       (pend_cmd        ),
   .pend_width_i     (pend_width      ),
   .pend_addr_i      (pend_addr       ),
   .sel_i            (wb_sel          ),
   .wdata_i          (wb_wdata        ),
   .pend_take_o      (pend_take       ),
   .wbd_dmem_stb_o   (wbd_dmem_stb_o  ),
   .wbd_dmem_adr_o   (wbd_dmem_adr_o  ),
   .wbd_dmem_we_o    (wbd_dmem_we_o   ),
   .wbd_dmem_dat_o   (wbd_dmem_dat_o  ),
   .wbd_dmem_sel_o   (wbd_dmem_sel_o  ),
   .wbd_dmem_dat_i   (wbd_dmem_dat_i  ),
   .wbd_dmem_ack_i   (wbd_dmem_ack_i  ),
   .wbd_dmem_err_i   (wbd_dmem_err_i  ),
   .rd_width_o       (rd_width        ),
   .rd_offset_o      (rd_offset       ),
   .rd_data_o        (rd_data         ),
   .core_dmem_resp_o (core_dmem_resp_o)
);

endmodule : ycr_intf

//--- sim/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
   parameter int unsigned PERIOD = 20                 // Clock period in ns
) (
   output logic clk_o                                 // Free-running clock
);

initial begin
   clk_o = 1'b0;                                      // Start low
end

always begin
   #(PERIOD / 2) clk_o = ~clk_o;                      // Half period toggle
end

endmodule : tb_clk_gen

//--- sim/ycr_wb_slave_model.sv
`timescale 1ns/10ps

module ycr_wb_slave_model #(
   parameter logic [31:0] ERR_ADDR = 32'h0000_00F0    // Address that answers err
) (
   input  logic                 clk_i,                // Bus clock
   input  logic                 rst_n_i,              // Async reset
   input  logic                 stb_i,                // Strobe
   input  ycr_wb_pkg::wb_data_t adr_i,                // Address
   input  logic                 we_i,                 // Write
   input  ycr_wb_pkg::wb_data_t dat_i,                // Write data
   input  ycr_wb_pkg::wb_sel_t  sel_i,                // Byte enables
   input  logic [1:0]           delay_i,              // Cycles before ack
   output ycr_wb_pkg::wb_data_t dat_o,                // Read data
   output logic                 ack_o,                // Acknowledge
   output logic                 err_o                 // Error
);

import ycr_wb_pkg::*;

wb_data_t   mem [0:63];                               // 64-word storage
logic [1:0] wait_cnt;                                 // Cycles waited so far
logic [5:0] idx;                                      // Word index

assign idx = adr_i[7:2];

// Each byte carries its own address
function automatic wb_data_t fill_word(int unsigned i);
   logic [7:0] a;
   a = 8'(i * 4);
   return {a + 8'd3, a + 8'd2, a + 8'd1, a} ^ 32'h5A5A_5A5A;
endfunction

always_ff @(posedge clk_i or negedge rst_n_i) begin
   if (!rst_n_i) begin
      ack_o    <= 1'b0;
      err_o    <= 1'b0;
      dat_o    <= '0;
      wait_cnt <= '0;
      for (int i = 0; i < 64; i++) begin
         mem[i] <= fill_word(i);                      // Reload pattern
      end
   end else begin
      ack_o <= 1'b0;                                  // Single-cycle pulses
      err_o <= 1'b0;
      if (stb_i && !ack_o && !err_o) begin
         if (wait_cnt == delay_i) begin
            wait_cnt <= '0;
            if (adr_i == ERR_ADDR) begin
               err_o <= 1'b1;                         // No access done
            end else begin
               ack_o <= 1'b1;
               dat_o <= mem[idx];
               if (we_i) begin
                  for (int b = 0; b < 4; b++) begin
                     if (sel_i[b]) mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
                  end
               end
            end
         end else begin
            wait_cnt <= wait_cnt + 2'd1;              // Still stalling
         end
      end
   end
end

endmodule : ycr_wb_slave_model

//--- sim/ycr_intf_tb.sv
`timescale 1ns/10ps

module ycr_intf_tb;

import ycr_mem_pkg::*;
import ycr_wb_pkg::*;

localparam int unsigned CLK_PERIOD = 20;
localparam dmem_addr_t  ERR_ADDR   = 32'h0000_00F0;

typedef struct {
   dmem_cmd_e   cmd;
   dmem_width_e width;
   dmem_addr_t  addr;
   dmem_data_t  wdata;
   bit          pipe;                                 // Issue with previous in flight
   dmem_resp_e  exp_resp;
   dmem_data_t  exp_rdata;
} entry_t;

logic        clk;
logic        rst_n;
logic        cpu_rst_n;
logic        req;
logic        req_ack;
dmem_cmd_e   cmd;
dmem_width_e width;
dmem_addr_t  addr;
dmem_data_t  wdata;
dmem_data_t  rdata;
dmem_resp_e  resp;
logic        stb;
logic        we;
logic        ack;
logic        err;
wb_data_t    wb_adr;
wb_data_t    wb_wdat;                                 // Master to slave
wb_data_t    wb_rdat;                                 // Slave to master
wb_sel_t     sel;
logic [1:0]  ack_delay;

entry_t      stim_q[$];                               // Stimulus and expected values
dmem_data_t  shadow [0:63];                           // Reference memory
int          launch_idx;
int          resp_idx;
int unsigned rng_init;
bit          table_ready;
bit          stb_q;

tb_clk_gen #(.PERIOD(CLK_PERIOD)) i_clk_gen (.clk_o(clk));

ycr_intf #(.RST_SYNC_STAGES(2)) i_ycr_intf (
   .core_clk_i (clk), .rst_n_i (rst_n), .cpu_intf_rst_n_i (cpu_rst_n),
   .core_dmem_req_i (req), .core_dmem_cmd_i (cmd), .core_dmem_width_i (width),
   .core_dmem_addr_i (addr), .core_dmem_wdata_i (wdata), .core_dmem_req_ack_o (req_ack),
   .core_dmem_rdata_o (rdata), .core_dmem_resp_o (resp),
   .wbd_dmem_stb_o (stb), .wbd_dmem_adr_o (wb_adr), .wbd_dmem_we_o (we),
   .wbd_dmem_dat_o (wb_wdat), .wbd_dmem_sel_o (sel), .wbd_dmem_dat_i (wb_rdat),
   .wbd_dmem_ack_i (ack), .wbd_dmem_err_i (err)
);

ycr_wb_slave_model #(.ERR_ADDR(ERR_ADDR)) i_wb_slave (
   .clk_i (clk), .rst_n_i (rst_n), .stb_i (stb), .adr_i (wb_adr), .we_i (we),
   .dat_i (wb_wdat), .sel_i (sel), .delay_i (ack_delay), .dat_o (wb_rdat),
   .ack_o (ack), .err_o (err)
);

// ------------------------------------------------------------
// Reference model
// ------------------------------------------------------------
function automatic dmem_data_t fill_word(int unsigned idx);
   logic [7:0] a;
   a = 8'(idx * 4);
   return {a + 8'd3, a + 8'd2, a + 8'd1, a} ^ 32'h5A5A_5A5A;
endfunction

function automatic wb_sel_t lane_sel(dmem_width_e w, logic [1:0] off);
   case (w)
      BYTE:    return 4'b0001 << off;
      HWORD:   return off[1] ? 4'b1100 : 4'b0011;
      default: return 4'b1111;
   endcase
endfunction

function automatic dmem_data_t read_extract(dmem_data_t word, dmem_width_e w, logic [1:0] off);
   dmem_data_t v;
   v = word >> (8 * off);                             // Lane down to bit 0
   case (w)
      BYTE:    return v & 32'h0000_00FF;
      HWORD:   return v & 32'h0000_FFFF;
      default: return v;
   endcase
endfunction

task automatic add_entry(dmem_cmd_e c, dmem_width_e w, dmem_addr_t a, dmem_data_t d, bit p);
   entry_t     e;
   wb_sel_t    s;
   dmem_data_t sd;
   e = '{cmd: c, width: w, addr: a, wdata: d, pipe: p, exp_resp: RDY, exp_rdata: '0};
   s  = lane_sel(w, a[1:0]);
   sd = d << (8 * a[1:0]);
   if (a == ERR_ADDR) begin
      e.exp_resp = ER;                                // Memory left untouched
   end else if (c == WRITE) begin
      for (int b = 0; b < 4; b++) begin
         if (s[b]) shadow[a[7:2]][8*b +: 8] = sd[8*b +: 8];
      end
   end else begin
      e.exp_rdata = read_extract(shadow[a[7:2]], w, a[1:0]);
   end
   stim_q.push_back(e);
endtask

task automatic build_table();
   add_entry(WRITE, WORD,  32'h10, 32'hDEAD_BEEF, 0);   // Word round trip
   add_entry(READ,  WORD,  32'h10, '0, 0);
   add_entry(WRITE, BYTE,  32'h20, 32'h0000_00A1, 0);   // Bytes at each offset
   add_entry(WRITE, BYTE,  32'h21, 32'h0000_00B2, 0);
   add_entry(WRITE, BYTE,  32'h22, 32'h0000_00C3, 0);
   add_entry(WRITE, BYTE,  32'h23, 32'h0000_00D4, 0);
   add_entry(READ,  WORD,  32'h20, '0, 0);
   add_entry(WRITE, HWORD, 32'h24, 32'h0000_1357, 0);   // Halves at 0 and 2
   add_entry(WRITE, HWORD, 32'h26, 32'h0000_9BDF, 0);
   add_entry(READ,  WORD,  32'h24, '0, 0);
   add_entry(WRITE, BYTE,  32'h29, 32'h0000_0077, 0);   // Merge into fill
   add_entry(READ,  WORD,  32'h28, '0, 0);
   for (int i = 0; i < 4; i++) begin
      add_entry(READ, BYTE, 32'h20 + i, '0, 0);         // Byte extraction
   end
   add_entry(READ,  HWORD, 32'h24, '0, 0);
   add_entry(READ,  HWORD, 32'h26, '0, 0);
   add_entry(READ,  BYTE,  32'h33, '0, 0);
   add_entry(READ,  HWORD, 32'h36, '0, 0);
   add_entry(WRITE, WORD,  ERR_ADDR, 32'hFFFF_FFFF, 0); // Bus error
   add_entry(READ,  WORD,  ERR_ADDR, '0, 0);
   add_entry(READ,  WORD,  32'h10, '0, 0);              // Recovery
   add_entry(WRITE, WORD,  32'h40, 32'h0BAD_F00D, 0);   // Back-to-back group
   add_entry(READ,  WORD,  32'h40, '0, 1);
   add_entry(WRITE, HWORD, 32'h46, 32'h0000_C0DE, 1);
   add_entry(READ,  WORD,  32'h44, '0, 1);
endtask

// ------------------------------------------------------------
// Checking
// ------------------------------------------------------------
task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
   if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("Test failures found");
      $fatal(1);
   end
endtask

// Bus launch and core response monitor
always @(negedge clk) begin
   if (stb && !stb_q) begin
      check_value("launch index in range", launch_idx < stim_q.size(), 1);
      check_value("wbd_dmem_adr_o", wb_adr, stim_q[launch_idx].addr);
      check_value("wbd_dmem_we_o", we, stim_q[launch_idx].cmd == WRITE);
      check_value("wbd_dmem_sel_o", sel,
                  lane_sel(stim_q[launch_idx].width, stim_q[launch_idx].addr[1:0]));
      if (stim_q[launch_idx].cmd == WRITE) begin
         check_value("wbd_dmem_dat_o", wb_wdat,
                     stim_q[launch_idx].wdata << (8 * stim_q[launch_idx].addr[1:0]));
      end
      launch_idx++;
   end
   stb_q = stb;
   if (resp !== IDLE) begin
      check_value("response order", resp_idx < launch_idx, 1);
      check_value("core_dmem_resp_o", resp, stim_q[resp_idx].exp_resp);
      if (stim_q[resp_idx].exp_resp == RDY) begin
         check_value("core_dmem_rdata_o", rdata, stim_q[resp_idx].exp_rdata);
      end
      resp_idx++;
   end
end

// ------------------------------------------------------------
// Stimulus
// ------------------------------------------------------------
// Called at a falling edge; returns at the falling edge after acceptance
task automatic issue_request(input int i, input logic [1:0] delay);
   int   waits;
   logic stb_at_accept;
   waits = 0;
   if (!stim_q[i].pipe) ack_delay = delay;            // Bus idle here
   req   = 1'b1;
   cmd   = stim_q[i].cmd;
   width = stim_q[i].width;
   addr  = stim_q[i].addr;
   wdata = stim_q[i].wdata;
   #5;
   while (!req_ack) begin
      waits++;                                        // Holding register full
      @(negedge clk);
      #5;
   end
   stb_at_accept = stb;
   @(posedge clk);                                    // Taken here
   @(negedge clk);
   req = 1'b0;
   if (stim_q[i].pipe) begin
      check_value("wbd_dmem_stb_o at accept", stb_at_accept, 1);
      check_value("core_dmem_req_ack_o held low", waits > 0, 1);
   end
endtask

initial begin
   longint wd_ns;
   wait (table_ready);
   wd_ns = longint'(stim_q.size() + 1) * 20 * CLK_PERIOD;
   #(wd_ns);
   $display("timeout: only %0d of %0d responses arrived", resp_idx, stim_q.size());
   $display("Test failures found");
   $fatal(1);
end

initial begin
   logic [1:0] delay;
   bit         next_pipe;
   rng_init  = $urandom(68010);
   req       = 1'b0;
   cmd       = READ;
   width     = WORD;
   addr      = '0;
   wdata     = '0;
   ack_delay = '0;
   rst_n     = 1'b0;
   cpu_rst_n = 1'b0;
   for (int i = 0; i < 64; i++) begin
      shadow[i] = fill_word(i);
   end
   build_table();
   table_ready = 1'b1;
   repeat (4) @(negedge clk);
   rst_n     = 1'b1;
   cpu_rst_n = 1'b1;
   repeat (4) begin                                   // Quiet after reset
      @(negedge clk);
      check_value("core_dmem_req_ack_o", req_ack, 0);
      check_value("wbd_dmem_stb_o", stb, 0);
      check_value("wbd_dmem_we_o", we, 0);
      check_value("core_dmem_resp_o", resp, IDLE);
   end
   for (int i = 0; i < stim_q.size(); i++) begin
      next_pipe = (i + 1 < stim_q.size()) && stim_q[i+1].pipe;
      delay     = next_pipe ? $urandom_range(3, 2) : $urandom_range(3, 0);
      if (!stim_q[i].pipe) begin
         while (resp_idx != i) @(posedge clk);        // Previous one done
         @(negedge clk);
      end
      issue_request(i, delay);
   end
   while (resp_idx != stim_q.size()) @(posedge clk);
   check_value("launch count", launch_idx, stim_q.size());
   $display("All tests passed!");
   $finish;
end

endmodule : ycr_intf_tb

//--- ycr_intf.f
rtl/ycr_mem_pkg.sv
rtl/ycr_wb_pkg.sv
rtl/ycr_reset_sync.sv
rtl/ycr_dmem_req_capture.sv
rtl/ycr_dmem_lane_align.sv
rtl/ycr_dmem_wb_master.sv
rtl/ycr_intf.sv
sim/tb_clk_gen.sv
sim/ycr_wb_slave_model.sv
sim/ycr_intf_tb.sv

//--- Bender.yml
package:
  name: ycr_intf

sources:
  # Packages first, then leaf modules, then the top level
  - rtl/ycr_mem_pkg.sv
  - rtl/ycr_wb_pkg.sv
  - rtl/ycr_reset_sync.sv
  - rtl/ycr_dmem_req_capture.sv
  - rtl/ycr_dmem_lane_align.sv
  - rtl/ycr_dmem_wb_master.sv
  - rtl/ycr_intf.sv

  - target: test
    files:
      - sim/tb_clk_gen.sv
      - sim/ycr_wb_slave_model.sv
      - sim/ycr_intf_tb.sv
